//--- hw/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// processor word and address
`define CACHE_ADDR_LEN 32
`define CACHE_DATA_LEN 64
`define CACHE_STRB_LEN (`CACHE_DATA_LEN / 8)

// set geometry, 16 sets of 32-byte blocks
`define CACHE_INDEX_LEN 4
`define CACHE_OFFSET_LEN 5
`define CACHE_TAG_LEN (`CACHE_ADDR_LEN - `CACHE_INDEX_LEN - `CACHE_OFFSET_LEN)
`define CACHE_WAY_NUM 2

// a block is split into word banks
`define CACHE_BANK_LEN 2
`define CACHE_BANK_NUM (1 << `CACHE_BANK_LEN)
`define CACHE_BLOCK_LEN (`CACHE_BANK_NUM * `CACHE_DATA_LEN)

// start value of the replacement LFSR, must not be zero
`define CACHE_LFSR_SEED 16'hace1

`endif

//--- hw/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	// way number and one whole block
	typedef logic [$clog2(`CACHE_WAY_NUM)-1:0] way_t;
	typedef logic [`CACHE_BLOCK_LEN-1:0] block_t;

	// address as the cache splits it
	typedef struct packed {
		logic [`CACHE_TAG_LEN-1:0] tag;
		logic [`CACHE_INDEX_LEN-1:0] index;
		logic [`CACHE_BANK_LEN-1:0] bank;
		logic [`CACHE_OFFSET_LEN-`CACHE_BANK_LEN-1:0] byte_off;
	} addr_t;

	// one processor request, op is 1 for a store
	typedef struct packed {
		logic op;
		addr_t addr;
		logic [`CACHE_STRB_LEN-1:0] wstrb;
		logic [`CACHE_DATA_LEN-1:0] wdata;
	} cache_req_t;

	// bookkeeping of one line
	typedef struct packed {
		logic valid;
		logic dirty;
		logic [`CACHE_TAG_LEN-1:0] tag;
	} tag_entry_t;

	// tag entry update, the entry becomes valid when en is set
	typedef struct packed {
		logic en;
		way_t way;
		logic [`CACHE_INDEX_LEN-1:0] index;
		logic [`CACHE_TAG_LEN-1:0] tag;
		logic dirty;
	} line_fill_t;

	// one word write into the data banks
	typedef struct packed {
		logic en;
		way_t way;
		logic [`CACHE_INDEX_LEN-1:0] index;
		logic [`CACHE_BANK_LEN-1:0] bank;
		logic [`CACHE_STRB_LEN-1:0] strb;
		logic [`CACHE_DATA_LEN-1:0] data;
	} data_wr_t;

endpackage

//--- hw/tag_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tag_store import cache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [`CACHE_INDEX_LEN-1:0] rd_index,
	input  logic [`CACHE_TAG_LEN-1:0] req_tag,
	input  line_fill_t line_fill,
	output tag_entry_t way_tag [`CACHE_WAY_NUM],
	output logic [`CACHE_WAY_NUM-1:0] way_hit,
	output way_t victim_way
);

	localparam int SET_NUM = 1 << `CACHE_INDEX_LEN;

	logic [`CACHE_TAG_LEN-1:0] tag_mem [`CACHE_WAY_NUM][SET_NUM];
	logic [SET_NUM-1:0] valid_q [`CACHE_WAY_NUM];
	logic [SET_NUM-1:0] dirty_q [`CACHE_WAY_NUM];
	logic [15:0] lfsr_q;
	logic lfsr_fb;

	// tag of a refilled or stored-to line
	always_ff @(posedge clk) begin
		if (line_fill.en) begin
			tag_mem[line_fill.way][line_fill.index] <= line_fill.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			// sweep every set of every way back to invalid
			for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else if (line_fill.en) begin
			valid_q[line_fill.way][line_fill.index] <= 1'b1;
			dirty_q[line_fill.way][line_fill.index] <= line_fill.dirty;
		end
	end

	// one cycle read of all ways at the same set
	always_ff @(posedge clk) begin
		for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
			way_tag[w].valid <= valid_q[w][rd_index];
			way_tag[w].dirty <= dirty_q[w][rd_index];
			way_tag[w].tag <= tag_mem[w][rd_index];
		end
	end

	always_comb begin
		for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
			way_hit[w] = way_tag[w].valid && (way_tag[w].tag == req_tag);
		end
	end

	// x^16 + x^15 + x^13 + x^4 + 1 stepping on every clock
	assign lfsr_fb = lfsr_q[15] ^ lfsr_q[14] ^ lfsr_q[12] ^ lfsr_q[3];

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr_q <= `CACHE_LFSR_SEED;
		end else begin
			lfsr_q <= {lfsr_q[14:0], lfsr_fb};
		end
	end

	// invalid way first, then a clean one, else a pseudo random pick
	always_comb begin
		victim_way = way_t'(^lfsr_q);
		for (int w = `CACHE_WAY_NUM - 1; w >= 0; w--) begin
			if (!way_tag[w].dirty) begin
				victim_way = way_t'(w);
			end
		end
		for (int w = `CACHE_WAY_NUM - 1; w >= 0; w--) begin
			if (!way_tag[w].valid) begin
				victim_way = way_t'(w);
			end
		end
	end

	// the controller installs a tag only after a miss, so no duplicates
	a_single_hit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(way_hit))
		else $error("tag hit in more than one way");

endmodule

//--- hw/data_store.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module data_store import cache_pkg::*; (
	input  logic clk,
	input  logic [`CACHE_INDEX_LEN-1:0] rd_index,
	input  data_wr_t data_wr,
	output block_t way_block [`CACHE_WAY_NUM]
);

	localparam int SET_NUM = 1 << `CACHE_INDEX_LEN;

	// one word RAM per way and bank
	logic [`CACHE_DATA_LEN-1:0] bank_mem [`CACHE_WAY_NUM][`CACHE_BANK_NUM][SET_NUM];

	// a write only touches the strobed bytes of one bank
	always_ff @(posedge clk) begin
		if (data_wr.en) begin
			for (int i = 0; i < `CACHE_STRB_LEN; i++) begin
				if (data_wr.strb[i]) begin
					bank_mem[data_wr.way][data_wr.bank][data_wr.index][i*8 +: 8]
						<= data_wr.data[i*8 +: 8];
				end
			end
		end
	end

	// all banks read together, bank 0 in the low word of the block
	always_ff @(posedge clk) begin
		for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
			for (int b = 0; b < `CACHE_BANK_NUM; b++) begin
				way_block[w][b * `CACHE_DATA_LEN +: `CACHE_DATA_LEN]
					<= bank_mem[w][b][rd_index];
			end
		end
	end

endmodule

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_ctrl import cache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_req_t req,
	output logic addr_ok,
	output logic data_ok,
	output logic [`CACHE_DATA_LEN-1:0] rdata,
	output logic rd_valid,
	output addr_t rd_addr,
	input  logic rd_dvalid,
	input  logic rd_dlast,
	input  logic [`CACHE_DATA_LEN-1:0] rd_data,
	output logic wr_valid,
	output addr_t wr_addr,
	output block_t wr_data,
	input  logic wr_ready,
	output logic [`CACHE_INDEX_LEN-1:0] rd_index,
	output logic [`CACHE_TAG_LEN-1:0] req_tag,
	input  tag_entry_t way_tag [`CACHE_WAY_NUM],
	input  logic [`CACHE_WAY_NUM-1:0] way_hit,
	input  way_t victim_way,
	output line_fill_t line_fill,
	input  block_t way_block [`CACHE_WAY_NUM],
	output data_wr_t data_wr
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_LOOKUP,
		S_WRITEBACK,
		S_REFILL,
		S_DONE
	} state_t;

	state_t state_q;
	state_t state_d;

	// request buffer, miss buffer and refill progress
	cache_req_t req_q;
	way_t victim_q;
	logic [`CACHE_TAG_LEN-1:0] victim_tag_q;
	block_t victim_block_q;
	logic [`CACHE_BANK_LEN-1:0] beat_q;
	logic [`CACHE_DATA_LEN-1:0] result_q;

	logic hit;
	way_t hit_way;
	logic [`CACHE_DATA_LEN-1:0] hit_word;
	logic victim_dirty;
	logic refill_beat;
	logic [`CACHE_DATA_LEN-1:0] fill_word;

	assign hit = |way_hit;

	always_comb begin
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAY_NUM; w++) begin
			if (way_hit[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign hit_word = way_block[hit_way][req_q.addr.bank * `CACHE_DATA_LEN +: `CACHE_DATA_LEN];

	// only a dirty victim costs a write-back
	assign victim_dirty = way_tag[victim_way].valid && way_tag[victim_way].dirty;

	assign refill_beat = (state_q == S_REFILL) && rd_dvalid;

	// refill word with the pending store bytes laid over it
	always_comb begin
		fill_word = rd_data;
		if (req_q.op && beat_q == req_q.addr.bank) begin
			for (int i = 0; i < `CACHE_STRB_LEN; i++) begin
				if (req_q.wstrb[i]) begin
					fill_word[i*8 +: 8] = req_q.wdata[i*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (req_valid) begin
					state_d = S_LOOKUP;
				end
			end
			S_LOOKUP: begin
				if (hit) begin
					state_d = S_IDLE;
				end else if (victim_dirty) begin
					state_d = S_WRITEBACK;
				end else begin
					state_d = S_REFILL;
				end
			end
			S_WRITEBACK: begin
				if (wr_ready) begin
					state_d = S_REFILL;
				end
			end
			S_REFILL: begin
				if (rd_dvalid && rd_dlast) begin
					state_d = S_DONE;
				end
			end
			S_DONE: begin
				state_d = S_IDLE;
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
			beat_q <= '0;
		end else begin
			state_q <= state_d;
			// beats arrive in bank order starting at 0
			if (state_q == S_LOOKUP) begin
				beat_q <= '0;
			end else if (refill_beat) begin
				beat_q <= beat_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == S_IDLE && req_valid) begin
			req_q <= req;
		end
		if (state_q == S_LOOKUP && !hit) begin
			victim_q <= victim_way;
			victim_tag_q <= way_tag[victim_way].tag;
			victim_block_q <= way_block[victim_way];
		end
		// keep the requested word for the response in done
		if (refill_beat && beat_q == req_q.addr.bank) begin
			result_q <= fill_word;
		end
	end

	// store hits and refill beats are the only writers of both stores
	always_comb begin
		data_wr = '0;
		line_fill = '0;
		if (state_q == S_LOOKUP && hit && req_q.op) begin
			data_wr.en = 1'b1;
			data_wr.way = hit_way;
			data_wr.index = req_q.addr.index;
			data_wr.bank = req_q.addr.bank;
			data_wr.strb = req_q.wstrb;
			data_wr.data = req_q.wdata;
			line_fill.en = 1'b1;
			line_fill.way = hit_way;
			line_fill.index = req_q.addr.index;
			line_fill.tag = req_q.addr.tag;
			line_fill.dirty = 1'b1;
		end else if (refill_beat) begin
			data_wr.en = 1'b1;
			data_wr.way = victim_q;
			data_wr.index = req_q.addr.index;
			data_wr.bank = beat_q;
			data_wr.strb = '1;
			data_wr.data = fill_word;
			if (rd_dlast) begin
				line_fill.en = 1'b1;
				line_fill.way = victim_q;
				line_fill.index = req_q.addr.index;
				line_fill.tag = req_q.addr.tag;
				line_fill.dirty = req_q.op;
			end
		end
	end

	// index follows the incoming request only while idle
	assign rd_index = (state_q == S_IDLE) ? req.addr.index : req_q.addr.index;
	assign req_tag = req_q.addr.tag;

	assign addr_ok = (state_q == S_IDLE);
	assign data_ok = (state_q == S_LOOKUP && hit) || (state_q == S_DONE);
	assign rdata = (state_q == S_LOOKUP) ? hit_word : result_q;

	assign wr_valid = (state_q == S_WRITEBACK);
	assign wr_addr = '{tag: victim_tag_q, index: req_q.addr.index, bank: '0, byte_off: '0};
	assign wr_data = victim_block_q;

	assign rd_valid = (state_q == S_REFILL);
	assign rd_addr = '{tag: req_q.addr.tag, index: req_q.addr.index, bank: '0, byte_off: '0};

	// the beat counter and the memory agree on which beat ends the block
	a_last_beat: assert property (@(posedge clk) disable iff (rst)
		refill_beat |-> (rd_dlast == (beat_q == '1)))
		else $error("rd_dlast out of step with the beat counter");

	// write-back request must not move while memory stalls it
	a_wr_hold: assert property (@(posedge clk) disable iff (rst)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
		else $error("write-back request changed before wr_ready");

endmodule

//--- hw/cache_top.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_top import cache_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	input  cache_req_t req,
	output logic addr_ok,
	output logic data_ok,
	output logic [`CACHE_DATA_LEN-1:0] rdata,
	output logic rd_valid,
	output addr_t rd_addr,
	input  logic rd_dvalid,
	input  logic rd_dlast,
	input  logic [`CACHE_DATA_LEN-1:0] rd_data,
	output logic wr_valid,
	output addr_t wr_addr,
	output block_t wr_data,
	input  logic wr_ready
);

	logic [`CACHE_INDEX_LEN-1:0] rd_index;
	logic [`CACHE_TAG_LEN-1:0] req_tag;
	tag_entry_t way_tag [`CACHE_WAY_NUM];
	logic [`CACHE_WAY_NUM-1:0] way_hit;
	way_t victim_way;
	line_fill_t line_fill;
	block_t way_block [`CACHE_WAY_NUM];
	data_wr_t data_wr;

	cache_ctrl u_ctrl (
		.clk(clk),
		.rst(rst),
		.req_valid(req_valid),
		.req(req),
		.addr_ok(addr_ok),
		.data_ok(data_ok),
		.rdata(rdata),
		.rd_valid(rd_valid),
		.rd_addr(rd_addr),
		.rd_dvalid(rd_dvalid),
		.rd_dlast(rd_dlast),
		.rd_data(rd_data),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ready(wr_ready),
		.rd_index(rd_index),
		.req_tag(req_tag),
		.way_tag(way_tag),
		.way_hit(way_hit),
		.victim_way(victim_way),
		.line_fill(line_fill),
		.way_block(way_block),
		.data_wr(data_wr)
	);

	tag_store u_tags (
		.clk(clk),
		.rst(rst),
		.rd_index(rd_index),
		.req_tag(req_tag),
		.line_fill(line_fill),
		.way_tag(way_tag),
		.way_hit(way_hit),
		.victim_way(victim_way)
	);

	data_store u_data (
		.clk(clk),
		.rd_index(rd_index),
		.data_wr(data_wr),
		.way_block(way_block)
	);

endmodule

//--- sim/mem_model.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module mem_model import cache_pkg::*; #(
	parameter int SEED = 1
) (
	input  logic clk,
	input  logic rst,
	input  logic rd_valid,
	input  addr_t rd_addr,
	output logic rd_dvalid,
	output logic rd_dlast,
	output logic [`CACHE_DATA_LEN-1:0] rd_data,
	input  logic wr_valid,
	input  addr_t wr_addr,
	input  block_t wr_data,
	output logic wr_ready
);

	// words are kept by low tag bits, index and bank
	localparam int WORDS = 1 << 10;

	logic [`CACHE_DATA_LEN-1:0] mem [WORDS];
	logic [`CACHE_BANK_LEN-1:0] beat;
	integer seed;

	function automatic logic [9:0] word_key(input addr_t a, input logic [1:0] bank);
		return {a.tag[3:0], a.index, bank};
	endfunction

	// each word holds its own byte address and its inverse
	initial begin
		logic [31:0] byte_addr;
		seed = SEED;
		beat = '0;
		rd_dvalid = 1'b0;
		rd_dlast = 1'b0;
		rd_data = '0;
		wr_ready = 1'b0;
		for (int k = 0; k < WORDS; k++) begin
			byte_addr = k * 8;
			mem[k] = {~byte_addr, byte_addr};
		end
	end

	// all outputs change on the falling edge
	always @(negedge clk) begin : drive
		logic [31:0] rnd;
		rnd = $random(seed);
		if (rst) begin
			beat = '0;
			rd_dvalid = 1'b0;
			rd_dlast = 1'b0;
			wr_ready = 1'b0;
		end else begin
			// a beat shown last cycle was taken at the rising edge, wraps after the last
			if (rd_dvalid) begin
				beat = beat + 1'b1;
			end
			if (rd_valid && rnd[0]) begin
				rd_dvalid = 1'b1;
				rd_dlast = (beat == 2'd3);
				rd_data = mem[word_key(rd_addr, beat)];
			end else begin
				rd_dvalid = 1'b0;
				rd_dlast = 1'b0;
			end
			// ready about one cycle in four
			wr_ready = (rnd[5:4] == 2'b00);
		end
	end

	always @(posedge clk) begin
		if (!rst && wr_valid && wr_ready) begin
			for (int b = 0; b < `CACHE_BANK_NUM; b++) begin
				mem[word_key(wr_addr, b[1:0])] = wr_data[b*`CACHE_DATA_LEN +: `CACHE_DATA_LEN];
			end
		end
	end

endmodule

//--- sim/tb_cache.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_cache import cache_pkg::*; ();

	localparam int MIX_REQS = 200;
	localparam int EVICT_REQS = 200;
	localparam int FLUSH_REQS = 16;
	localparam int TOTAL_REQS = MIX_REQS + EVICT_REQS + 2 * FLUSH_REQS;
	// lookup, write-back under back-pressure, four gapped beats and done
	localparam int WORST_MISS = 40;
	localparam int CYCLE_LIMIT = 4 * TOTAL_REQS * WORST_MISS;

	logic clk;
	logic rst;
	logic req_valid;
	cache_req_t req;
	logic addr_ok;
	logic data_ok;
	logic [`CACHE_DATA_LEN-1:0] rdata;
	logic rd_valid;
	addr_t rd_addr;
	logic rd_dvalid;
	logic rd_dlast;
	logic [`CACHE_DATA_LEN-1:0] rd_data;
	logic wr_valid;
	addr_t wr_addr;
	block_t wr_data;
	logic wr_ready;

	integer seed;
	int errors;
	int cycles = 0;
	logic [`CACHE_DATA_LEN-1:0] shadow [1024];
	cache_req_t cur_req;
	logic [`CACHE_DATA_LEN-1:0] exp_word;
	logic expect_hit;
	logic have_last;
	logic accept;

	cache_top dut (.*);

	mem_model #(.SEED(48)) u_mem (
		.clk(clk),
		.rst(rst),
		.rd_valid(rd_valid),
		.rd_addr(rd_addr),
		.rd_dvalid(rd_dvalid),
		.rd_dlast(rd_dlast),
		.rd_data(rd_data),
		.wr_valid(wr_valid),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.wr_ready(wr_ready)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// same word layout as the memory model
	function automatic logic [9:0] word_key(input addr_t a, input logic [1:0] bank);
		return {a.tag[3:0], a.index, bank};
	endfunction

	function automatic block_t shadow_block(input addr_t a);
		block_t blk;
		for (int b = 0; b < `CACHE_BANK_NUM; b++) begin
			blk[b*`CACHE_DATA_LEN +: `CACHE_DATA_LEN] = shadow[word_key(a, b[1:0])];
		end
		return blk;
	endfunction

	task automatic log_failure(input string msg);
		errors++;
		$display("Fail %0t: %s", $time, msg);
	endtask

	assign accept = req_valid && addr_ok;

	reset_state: assert property (@(posedge clk)
		$fell(rst) |-> addr_ok && !data_ok && !rd_valid && !wr_valid)
		else log_failure("outputs wrong after reset");

	load_data: assert property (@(posedge clk) disable iff (rst)
		data_ok && !cur_req.op |-> rdata == exp_word)
		else log_failure($sformatf("load data %h", exp_word));

	hit_latency: assert property (@(posedge clk) disable iff (rst)
		accept && expect_hit |=> data_ok && !rd_valid)
		else log_failure("hit not answered next cycle");

	refill_addr: assert property (@(posedge clk) disable iff (rst)
		rd_valid |-> rd_addr.bank == '0 && rd_addr.byte_off == '0
			&& rd_addr.tag == cur_req.addr.tag && rd_addr.index == cur_req.addr.index)
		else log_failure("refill address");

	refill_end: assert property (@(posedge clk) disable iff (rst)
		rd_valid && rd_dvalid && rd_dlast |=> data_ok)
		else log_failure("no data_ok after last beat");

	wb_data: assert property (@(posedge clk) disable iff (rst)
		wr_valid && wr_ready |-> wr_addr.bank == '0 && wr_addr.byte_off == '0
			&& wr_data == shadow_block(wr_addr))
		else log_failure("write-back block");

	wb_hold: assert property (@(posedge clk) disable iff (rst)
		wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
		else log_failure("write-back moved while stalled");

	wb_no_refill: assert property (@(posedge clk) disable iff (rst)
		wr_valid |-> !rd_valid)
		else log_failure("refill during write-back");

	// random request that goes back to the last block one time in four
	task automatic make_req(input int ntags, output cache_req_t r);
		logic [31:0] rnd;
		int t;
		rnd = $random(seed);
		r = '0;
		if (have_last && rnd[3:0] < 4'd4) begin
			r.addr.tag = cur_req.addr.tag;
			r.addr.index = cur_req.addr.index;
		end else begin
			t = int'(rnd[15:8]) % ntags;
			r.addr.tag[3:0] = t[3:0];
			r.addr.index = rnd[16] ? 4'd10 : 4'd5;
		end
		r.addr.bank = rnd[18:17];
		r.op = rnd[19];
		r.wstrb = rnd[27:20];
		r.wdata = {$random(seed), $random(seed)};
	endtask

	// issue one request on the falling edge and wait for its data_ok
	task automatic run_req(input cache_req_t r);
		logic [`CACHE_DATA_LEN-1:0] word;
		logic [9:0] k;
		while (!addr_ok) begin
			@(negedge clk);
		end
		k = word_key(r.addr, r.addr.bank);
		expect_hit = have_last && r.addr.tag == cur_req.addr.tag
			&& r.addr.index == cur_req.addr.index;
		cur_req = r;
		have_last = 1'b1;
		word = shadow[k];
		exp_word = word;
		if (r.op) begin
			for (int i = 0; i < `CACHE_STRB_LEN; i++) begin
				if (r.wstrb[i]) begin
					word[i*8 +: 8] = r.wdata[i*8 +: 8];
				end
			end
			shadow[k] = word;
		end
		req = r;
		req_valid = 1'b1;
		@(negedge clk);
		req_valid = 1'b0;
		while (!data_ok) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	task automatic report_test(input string name, input int n, input int start_err);
		$display("%s: %0d requests, %0d errors", name, n, errors - start_err);
	endtask

	initial begin
		cache_req_t r;
		logic [9:0] k;
		int start_err;
		int t;
		clk = 1'b0;
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		seed = 48;
		errors = 0;
		have_last = 1'b0;
		expect_hit = 1'b0;
		cur_req = '0;
		exp_word = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 1024; i++) begin
			shadow[i] = u_mem.mem[i];
		end
		@(negedge clk);
		report_test("reset state", 0, 0);

		start_err = errors;
		repeat (MIX_REQS) begin
			make_req(3, r);
			run_req(r);
		end
		report_test("random mix", MIX_REQS, start_err);

		// five tags on two ways force evictions
		start_err = errors;
		repeat (EVICT_REQS) begin
			make_req(5, r);
			run_req(r);
		end
		report_test("evictions", EVICT_REQS, start_err);

		// stores to unused tags push every dirty line out
		start_err = errors;
		for (int x = 0; x < 2; x++) begin
			for (int i = 0; i < FLUSH_REQS; i++) begin
				r = '0;
				t = 8 + i % 8;
				r.op = 1'b1;
				r.addr.tag[3:0] = t[3:0];
				r.addr.index = (x == 0) ? 4'd5 : 4'd10;
				r.addr.bank = i[1:0];
				r.wstrb = '1;
				r.wdata = {$random(seed), $random(seed)};
				run_req(r);
			end
		end
		for (int tg = 0; tg < 5; tg++) begin
			for (int x = 0; x < 2; x++) begin
				for (int b = 0; b < `CACHE_BANK_NUM; b++) begin
					k = {tg[3:0], (x == 0) ? 4'd5 : 4'd10, b[1:0]};
					flush_match: assert (u_mem.mem[k] == shadow[k])
						else log_failure($sformatf("memory word %0h differs after flush", k));
				end
			end
		end
		report_test("flush", 2 * FLUSH_REQS, start_err);

		$display("tests: 4, errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+hw
hw/cache_pkg.sv
hw/tag_store.sv
hw/data_store.sv
hw/cache_ctrl.sv
hw/cache_top.sv
sim/mem_model.sv
sim/tb_cache.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cache
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) hw/cache_defines.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
